// File: rtl/cpuPkg.sv
package cpuPkg;

	////////////////////////////////////////////////////////////
	// Widths and depths
	////////////////////////////////////////////////////////////
	localparam int dataWidth = 32;
	localparam int regAddrWidth = 5;
	localparam int pcWidth = 8;
	localparam int dmemAddrWidth = 8;
	localparam int imemDepth = 1 << pcWidth;
	localparam int dmemDepth = 1 << dmemAddrWidth;

	////////////////////////////////////////////////////////////
	// Debug bus address map, byte addressed
	////////////////////////////////////////////////////////////
	localparam int busAddrWidth = 12;
	// Word index starts here
	localparam int busWordLsb = 2;
	// Set for instruction memory, clear for data memory
	localparam int busImemBit = 10;

	localparam logic [1:0] respOkay = 2'b00;
	localparam logic [1:0] respSlvErr = 2'b10;

	////////////////////////////////////////////////////////////
	// Encodings
	////////////////////////////////////////////////////////////
	typedef enum logic [5:0] {
		opRtype = 6'h00,
		opAddi = 6'h08,
		opOri = 6'h0d,
		opLui = 6'h0f,
		opLw = 6'h23,
		opSw = 6'h2b,
		opHalt = 6'h3f
	} opcodeT;

	typedef enum logic [5:0] {
		fnSll = 6'h00,
		fnAdd = 6'h20,
		fnSub = 6'h22,
		fnAnd = 6'h24,
		fnOr = 6'h25,
		fnSlt = 6'h2a
	} functT;

	typedef enum logic [2:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluSlt,
		aluSll,
		aluLui
	} aluOpT;

	typedef enum logic [1:0] {
		dbIdle,
		dbWait,
		dbResp
	} debugStateT;

endpackage

// File: rtl/instrDecoder.sv
`timescale 1ns/100ps

module instrDecoder (
	input cpuPkg::opcodeT opcode,
	input cpuPkg::functT funct,
	output cpuPkg::aluOpT aluOp,
	output logic useImm,
	output logic zeroExt,
	output logic useShamt,
	output logic regDst,
	output logic regWrite,
	output logic memWrite,
	output logic memToReg,
	output logic halt
);
	import cpuPkg::*;

	always_comb begin
		// No-op unless the table below says otherwise
		aluOp = aluAdd;
		useImm = 1'b0;
		zeroExt = 1'b0;
		useShamt = 1'b0;
		regDst = 1'b0;
		regWrite = 1'b0;
		memWrite = 1'b0;
		memToReg = 1'b0;
		halt = 1'b0;
		case (opcode)
			opRtype: begin
				regDst = 1'b1;
				regWrite = 1'b1;
				case (funct)
					fnAdd: aluOp = aluAdd;
					fnSub: aluOp = aluSub;
					fnAnd: aluOp = aluAnd;
					fnOr: aluOp = aluOr;
					fnSlt: aluOp = aluSlt;
					fnSll: begin
						aluOp = aluSll;
						useShamt = 1'b1;
					end
					// Unknown funct writes nothing
					default: regWrite = 1'b0;
				endcase
			end
			opAddi: begin
				useImm = 1'b1;
				regWrite = 1'b1;
			end
			opOri: begin
				aluOp = aluOr;
				useImm = 1'b1;
				zeroExt = 1'b1;
				regWrite = 1'b1;
			end
			opLui: begin
				aluOp = aluLui;
				useImm = 1'b1;
				regWrite = 1'b1;
			end
			opLw: begin
				useImm = 1'b1;
				regWrite = 1'b1;
				memToReg = 1'b1;
			end
			opSw: begin
				useImm = 1'b1;
				memWrite = 1'b1;
			end
			opHalt: halt = 1'b1;
			default: halt = 1'b0;
		endcase
	end

endmodule

// File: rtl/regFile.sv
`timescale 1ns/100ps

module regFile (
	input logic clk,
	input logic reset,
	input logic [cpuPkg::regAddrWidth-1:0] readAddrA,
	input logic [cpuPkg::regAddrWidth-1:0] readAddrB,
	input logic writeEn,
	input logic [cpuPkg::regAddrWidth-1:0] writeAddr,
	input logic [cpuPkg::dataWidth-1:0] writeData,
	output logic [cpuPkg::dataWidth-1:0] readDataA,
	output logic [cpuPkg::dataWidth-1:0] readDataB
);
	import cpuPkg::*;

	logic [dataWidth-1:0] regs [1 << regAddrWidth];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < (1 << regAddrWidth); i++) begin
				regs[i] <= '0;
			end
		end else if (writeEn && writeAddr != '0) begin
			regs[writeAddr] <= writeData;
		end
	end

	// Write-through, a read in the write-back cycle sees the new value
	assign readDataA = (readAddrA == '0) ? '0 :
		(writeEn && writeAddr == readAddrA) ? writeData : regs[readAddrA];
	assign readDataB = (readAddrB == '0) ? '0 :
		(writeEn && writeAddr == readAddrB) ? writeData : regs[readAddrB];

endmodule

// File: rtl/alu.sv
`timescale 1ns/100ps

module alu (
	input cpuPkg::aluOpT aluOp,
	input logic [cpuPkg::dataWidth-1:0] operandA,
	input logic [cpuPkg::dataWidth-1:0] operandB,
	output logic [cpuPkg::dataWidth-1:0] result
);
	import cpuPkg::*;

	localparam int halfWidth = dataWidth / 2;

	always_comb begin
		case (aluOp)
			aluAdd: result = operandA + operandB;
			aluSub: result = operandA - operandB;
			aluAnd: result = operandA & operandB;
			aluOr: result = operandA | operandB;
			// Signed compare
			aluSlt: begin
				result = '0;
				result[0] = $signed(operandA) < $signed(operandB);
			end
			// Shift amount rides on operand A
			aluSll: result = operandB << operandA[4:0];
			aluLui: result = {operandB[halfWidth-1:0], {halfWidth{1'b0}}};
			default: result = '0;
		endcase
	end

endmodule

// File: rtl/pipeline.sv
`timescale 1ns/100ps

module pipeline (
	input logic clk,
	input logic reset,
	input logic run,
	input logic imemWe,
	input logic [cpuPkg::pcWidth-1:0] imemAddr,
	input logic [cpuPkg::dataWidth-1:0] imemData,
	input logic [cpuPkg::dataWidth-1:0] coreRdata,
	output logic halted,
	output logic coreReq,
	output logic coreWe,
	output logic [cpuPkg::dmemAddrWidth-1:0] coreAddr,
	output logic [cpuPkg::dataWidth-1:0] coreWdata
);
	import cpuPkg::*;

	logic [dataWidth-1:0] imem [imemDepth];
	logic [pcWidth-1:0] pc;
	logic haltSeen;
	logic fetchEn;

	// IF/ID
	logic ifIdValid;
	logic [dataWidth-1:0] ifIdInstr;

	// Decode
	aluOpT decAluOp;
	logic decUseImm, decZeroExt, decUseShamt, decRegDst;
	logic decRegWrite, decMemWrite, decMemToReg, decHalt;
	logic [dataWidth-1:0] rsData, rtData;

	// ID/EX
	logic idExValid;
	aluOpT idExAluOp;
	logic idExUseImm, idExZeroExt, idExUseShamt, idExRegDst;
	logic idExRegWrite, idExMemWrite, idExMemToReg, idExHalt;
	logic [dataWidth-1:0] idExRsData, idExRtData;
	logic [15:0] idExImm;
	logic [4:0] idExShamt;
	logic [regAddrWidth-1:0] idExRt, idExRd;

	// Execute
	logic [dataWidth-1:0] immExt, aluA, aluB, aluResult;
	logic [regAddrWidth-1:0] exDest;

	// EX/MEM
	logic exMemValid, exMemRegWrite, exMemMemWrite, exMemMemToReg, exMemHalt;
	logic [regAddrWidth-1:0] exMemDest;
	logic [dataWidth-1:0] exMemAluResult, exMemStoreData;

	// MEM/WB
	logic memWbValid, memWbRegWrite, memWbMemToReg;
	logic [regAddrWidth-1:0] memWbDest;
	logic [dataWidth-1:0] memWbAluResult;
	logic wbEn;
	logic [dataWidth-1:0] wbData;

	////////////////////////////////////////////////////////////
	// Fetch
	////////////////////////////////////////////////////////////
	// Bubbles while run is low and from the halt onwards
	assign fetchEn = run && !haltSeen && !(ifIdValid && decHalt);

	// Program loaded over the debug bus
	always_ff @(posedge clk) begin
		if (imemWe) begin
			imem[imemAddr] <= imemData;
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= '0;
			haltSeen <= 1'b0;
			ifIdValid <= 1'b0;
			idExValid <= 1'b0;
			exMemValid <= 1'b0;
			memWbValid <= 1'b0;
			halted <= 1'b0;
		end else begin
			if (fetchEn) begin
				pc <= pc + 1'b1;
			end
			if (ifIdValid && decHalt) begin
				haltSeen <= 1'b1;
			end
			ifIdValid <= fetchEn;
			idExValid <= ifIdValid;
			exMemValid <= idExValid;
			memWbValid <= exMemValid;
			// High from the cycle the halt sits in write-back
			if (exMemValid && exMemHalt) begin
				halted <= 1'b1;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Decode
	////////////////////////////////////////////////////////////
	instrDecoder decoder (
		.opcode(opcodeT'(ifIdInstr[31:26])),
		.funct(functT'(ifIdInstr[5:0])),
		.aluOp(decAluOp),
		.useImm(decUseImm),
		.zeroExt(decZeroExt),
		.useShamt(decUseShamt),
		.regDst(decRegDst),
		.regWrite(decRegWrite),
		.memWrite(decMemWrite),
		.memToReg(decMemToReg),
		.halt(decHalt)
	);

	regFile registers (
		.clk(clk),
		.reset(reset),
		.readAddrA(ifIdInstr[25:21]),
		.readAddrB(ifIdInstr[20:16]),
		.writeEn(wbEn),
		.writeAddr(memWbDest),
		.writeData(wbData),
		.readDataA(rsData),
		.readDataB(rtData)
	);

	////////////////////////////////////////////////////////////
	// Execute
	////////////////////////////////////////////////////////////
	assign immExt = idExZeroExt ? {{(dataWidth-16){1'b0}}, idExImm} :
		{{(dataWidth-16){idExImm[15]}}, idExImm};
	assign aluA = idExUseShamt ? {{(dataWidth-5){1'b0}}, idExShamt} : idExRsData;
	assign aluB = idExUseImm ? immExt : idExRtData;
	assign exDest = idExRegDst ? idExRd : idExRt;

	alu execUnit (
		.aluOp(idExAluOp),
		.operandA(aluA),
		.operandB(aluB),
		.result(aluResult)
	);

	////////////////////////////////////////////////////////////
	// Memory and write-back
	////////////////////////////////////////////////////////////
	assign coreReq = exMemValid && (exMemMemWrite || exMemMemToReg);
	assign coreWe = exMemValid && exMemMemWrite;
	// Byte address from the ALU, memory is word indexed
	assign coreAddr = exMemAluResult[busWordLsb +: dmemAddrWidth];
	assign coreWdata = exMemStoreData;

	// Load data arrives from the memory in this cycle
	assign wbData = memWbMemToReg ? coreRdata : memWbAluResult;
	assign wbEn = memWbValid && memWbRegWrite;

	// Stage payloads, qualified by the valid bits
	always_ff @(posedge clk) begin
		ifIdInstr <= imem[pc];

		idExAluOp <= decAluOp;
		idExUseImm <= decUseImm;
		idExZeroExt <= decZeroExt;
		idExUseShamt <= decUseShamt;
		idExRegDst <= decRegDst;
		idExRegWrite <= decRegWrite;
		idExMemWrite <= decMemWrite;
		idExMemToReg <= decMemToReg;
		idExHalt <= decHalt;
		idExRsData <= rsData;
		idExRtData <= rtData;
		idExImm <= ifIdInstr[15:0];
		idExShamt <= ifIdInstr[10:6];
		idExRt <= ifIdInstr[20:16];
		idExRd <= ifIdInstr[15:11];

		exMemRegWrite <= idExRegWrite;
		exMemMemWrite <= idExMemWrite;
		exMemMemToReg <= idExMemToReg;
		exMemHalt <= idExHalt;
		exMemDest <= exDest;
		exMemAluResult <= aluResult;
		exMemStoreData <= idExRtData;

		memWbRegWrite <= exMemRegWrite;
		memWbMemToReg <= exMemMemToReg;
		memWbDest <= exMemDest;
		memWbAluResult <= exMemAluResult;
	end

endmodule

// File: rtl/memArbiter.sv
`timescale 1ns/100ps

module memArbiter (
	input logic clk,
	input logic reset,
	input logic coreReq,
	input logic coreWe,
	input logic [cpuPkg::dmemAddrWidth-1:0] coreAddr,
	input logic [cpuPkg::dataWidth-1:0] coreWdata,
	input logic dbgReq,
	input logic dbgWe,
	input logic [cpuPkg::dmemAddrWidth-1:0] dbgAddr,
	input logic [cpuPkg::dataWidth-1:0] dbgWdata,
	output logic [cpuPkg::dataWidth-1:0] coreRdata,
	output logic dbgGnt,
	output logic [cpuPkg::dataWidth-1:0] dbgRdata
);
	import cpuPkg::*;

	logic [dataWidth-1:0] mem [dmemDepth];
	logic [dmemAddrWidth-1:0] accAddr;
	logic [dataWidth-1:0] accWdata;
	logic accWe;

	// Core never waits, debug takes the idle cycles
	assign dbgGnt = dbgReq && !coreReq;

	assign accAddr = coreReq ? coreAddr : dbgAddr;
	assign accWdata = coreReq ? coreWdata : dbgWdata;
	assign accWe = coreReq ? coreWe : (dbgGnt && dbgWe);

	always_ff @(posedge clk) begin
		if (accWe) begin
			mem[accAddr] <= accWdata;
		end
	end

	// Separate read registers, so debug data holds while the core keeps loading
	always_ff @(posedge clk) begin
		if (reset) begin
			coreRdata <= '0;
			dbgRdata <= '0;
		end else begin
			if (coreReq) begin
				coreRdata <= mem[accAddr];
			end
			if (dbgGnt) begin
				dbgRdata <= mem[accAddr];
			end
		end
	end

endmodule

// File: rtl/debugPort.sv
`timescale 1ns/100ps

module debugPort (
	input logic clk,
	input logic reset,
	input logic run,
	input logic awvalid,
	output logic awready,
	input logic [cpuPkg::busAddrWidth-1:0] awaddr,
	input logic wvalid,
	output logic wready,
	input logic [cpuPkg::dataWidth-1:0] wdata,
	output logic bvalid,
	input logic bready,
	output logic [1:0] bresp,
	input logic arvalid,
	output logic arready,
	input logic [cpuPkg::busAddrWidth-1:0] araddr,
	output logic rvalid,
	input logic rready,
	output logic [cpuPkg::dataWidth-1:0] rdata,
	output logic [1:0] rresp,
	input logic dbgGnt,
	input logic [cpuPkg::dataWidth-1:0] dbgRdata,
	output logic imemWe,
	output logic [cpuPkg::pcWidth-1:0] imemAddr,
	output logic [cpuPkg::dataWidth-1:0] imemData,
	output logic dbgReq,
	output logic dbgWe,
	output logic [cpuPkg::dmemAddrWidth-1:0] dbgAddr,
	output logic [cpuPkg::dataWidth-1:0] dbgWdata
);
	import cpuPkg::*;

	debugStateT state;
	logic writeAccept;
	logic readAccept;
	logic [dmemAddrWidth-1:0] wordIdx;
	logic [dataWidth-1:0] wrData;
	logic [1:0] respCode;

	// Address and data only together, writes win over reads
	assign writeAccept = (state == dbIdle) && awvalid && wvalid;
	assign arready = (state == dbIdle) && !awvalid && !wvalid;
	assign readAccept = arready && arvalid;
	assign awready = writeAccept;
	assign wready = writeAccept;

	assign imemAddr = wordIdx[pcWidth-1:0];
	assign imemData = wrData;
	assign dbgAddr = wordIdx;
	assign dbgWdata = wrData;
	assign bresp = respCode;
	assign rresp = respCode;
	assign rdata = (respCode == respOkay) ? dbgRdata : '0;

	////////////////////////////////////////////////////////////
	// Transaction FSM
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= dbIdle;
			bvalid <= 1'b0;
			rvalid <= 1'b0;
			dbgReq <= 1'b0;
			imemWe <= 1'b0;
		end else begin
			imemWe <= 1'b0;
			case (state)
				dbIdle: begin
					if (writeAccept && awaddr[busImemBit]) begin
						// Program memory is locked while the core runs
						imemWe <= !run;
						bvalid <= 1'b1;
						state <= dbResp;
					end else if (readAccept && araddr[busImemBit]) begin
						rvalid <= 1'b1;
						state <= dbResp;
					end else if (writeAccept || readAccept) begin
						dbgReq <= 1'b1;
						state <= dbWait;
					end
				end
				dbWait: begin
					if (dbgGnt) begin
						dbgReq <= 1'b0;
						bvalid <= dbgWe;
						rvalid <= !dbgWe;
						state <= dbResp;
					end
				end
				dbResp: begin
					if ((bvalid && bready) || (rvalid && rready)) begin
						bvalid <= 1'b0;
						rvalid <= 1'b0;
						state <= dbIdle;
					end
				end
				default: state <= dbIdle;
			endcase
		end
	end

	// Request payload, captured at acceptance
	always_ff @(posedge clk) begin
		if (writeAccept) begin
			wordIdx <= awaddr[busWordLsb +: dmemAddrWidth];
			wrData <= wdata;
			dbgWe <= 1'b1;
			respCode <= (awaddr[busImemBit] && run) ? respSlvErr : respOkay;
		end else if (readAccept) begin
			wordIdx <= araddr[busWordLsb +: dmemAddrWidth];
			dbgWe <= 1'b0;
			// Instruction memory is write only
			respCode <= araddr[busImemBit] ? respSlvErr : respOkay;
		end
	end

endmodule

// File: rtl/cpuTop.sv
`timescale 1ns/100ps

module cpuTop (
	input logic clk,
	input logic reset,
	input logic run,
	output logic halted,
	input logic awvalid,
	output logic awready,
	input logic [cpuPkg::busAddrWidth-1:0] awaddr,
	input logic wvalid,
	output logic wready,
	input logic [cpuPkg::dataWidth-1:0] wdata,
	output logic bvalid,
	input logic bready,
	output logic [1:0] bresp,
	input logic arvalid,
	output logic arready,
	input logic [cpuPkg::busAddrWidth-1:0] araddr,
	output logic rvalid,
	input logic rready,
	output logic [cpuPkg::dataWidth-1:0] rdata,
	output logic [1:0] rresp
);
	import cpuPkg::*;

	// Program load path
	logic imemWe;
	logic [pcWidth-1:0] imemAddr;
	logic [dataWidth-1:0] imemData;

	// Core side of the data memory
	logic coreReq;
	logic coreWe;
	logic [dmemAddrWidth-1:0] coreAddr;
	logic [dataWidth-1:0] coreWdata;
	logic [dataWidth-1:0] coreRdata;

	// Debug side of the data memory
	logic dbgReq;
	logic dbgWe;
	logic dbgGnt;
	logic [dmemAddrWidth-1:0] dbgAddr;
	logic [dataWidth-1:0] dbgWdata;
	logic [dataWidth-1:0] dbgRdata;

	pipeline core (
		.clk(clk),
		.reset(reset),
		.run(run),
		.imemWe(imemWe),
		.imemAddr(imemAddr),
		.imemData(imemData),
		.coreRdata(coreRdata),
		.halted(halted),
		.coreReq(coreReq),
		.coreWe(coreWe),
		.coreAddr(coreAddr),
		.coreWdata(coreWdata)
	);

	debugPort debugBus (
		.clk(clk),
		.reset(reset),
		.run(run),
		.awvalid(awvalid),
		.awready(awready),
		.awaddr(awaddr),
		.wvalid(wvalid),
		.wready(wready),
		.wdata(wdata),
		.bvalid(bvalid),
		.bready(bready),
		.bresp(bresp),
		.arvalid(arvalid),
		.arready(arready),
		.araddr(araddr),
		.rvalid(rvalid),
		.rready(rready),
		.rdata(rdata),
		.rresp(rresp),
		.dbgGnt(dbgGnt),
		.dbgRdata(dbgRdata),
		.imemWe(imemWe),
		.imemAddr(imemAddr),
		.imemData(imemData),
		.dbgReq(dbgReq),
		.dbgWe(dbgWe),
		.dbgAddr(dbgAddr),
		.dbgWdata(dbgWdata)
	);

	memArbiter dataMem (
		.clk(clk),
		.reset(reset),
		.coreReq(coreReq),
		.coreWe(coreWe),
		.coreAddr(coreAddr),
		.coreWdata(coreWdata),
		.dbgReq(dbgReq),
		.dbgWe(dbgWe),
		.dbgAddr(dbgAddr),
		.dbgWdata(dbgWdata),
		.coreRdata(coreRdata),
		.dbgGnt(dbgGnt),
		.dbgRdata(dbgRdata)
	);

endmodule

// File: testbench/cpuTb.sv
`timescale 1ns/100ps

module cpuTb;
	import cpuPkg::*;

	localparam int clkPeriod = 100;
	localparam int driveDelay = 10;
	localparam int progLen = 23;
	localparam int dataLen = 8;
	localparam int checkLen = 11;
	// First data word written by the program
	localparam int resultBase = 32;
	localparam int watchdogCycles = (progLen + checkLen) * 20;

	logic clk;
	logic reset;
	logic run;
	logic halted;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	logic [busAddrWidth-1:0] awaddr, araddr;
	logic [dataWidth-1:0] wdata, rdata;
	logic [1:0] bresp, rresp;

	// Stimulus and expected values
	logic [dataWidth-1:0] progMem [progLen];
	logic [dataWidth-1:0] dataTable [dataLen];
	string chkName [checkLen];
	logic [busAddrWidth-1:0] chkAddr [checkLen];
	logic [dataWidth-1:0] chkData [checkLen];
	logic [1:0] chkResp [checkLen];

	// Reference model state
	logic [dataWidth-1:0] modelRegs [32];
	logic [dataWidth-1:0] modelMem [dmemDepth];

	integer seed;
	int passCount, failCount, testErrors;
	logic [1:0] resp;
	logic [dataWidth-1:0] rdValue;

	cpuTop UUT (
		.clk(clk),
		.reset(reset),
		.run(run),
		.halted(halted),
		.awvalid(awvalid),
		.awready(awready),
		.awaddr(awaddr),
		.wvalid(wvalid),
		.wready(wready),
		.wdata(wdata),
		.bvalid(bvalid),
		.bready(bready),
		.bresp(bresp),
		.arvalid(arvalid),
		.arready(arready),
		.araddr(araddr),
		.rvalid(rvalid),
		.rready(rready),
		.rdata(rdata),
		.rresp(rresp)
	);

	initial clk = 1'b0;
	always #(clkPeriod / 2) clk = ~clk;

	////////////////////////////////////////////////////////////
	// Encoding and address helpers
	////////////////////////////////////////////////////////////
	function automatic logic [dataWidth-1:0] encodeR(input functT fn, input int rs,
			input int rt, input int rd, input int shamt);
		return {opRtype, 5'(rs), 5'(rt), 5'(rd), 5'(shamt), fn};
	endfunction

	function automatic logic [dataWidth-1:0] encodeI(input opcodeT op, input int rs,
			input int rt, input logic [15:0] imm);
		return {op, 5'(rs), 5'(rt), imm};
	endfunction

	function automatic logic [busAddrWidth-1:0] wordAddr(input int idx, input logic toImem);
		logic [busAddrWidth-1:0] addr;
		addr = '0;
		addr[busWordLsb +: dmemAddrWidth] = 8'(idx);
		addr[busImemBit] = toImem;
		return addr;
	endfunction

	task automatic buildProgram();
		int storeRegs [10] = '{4, 5, 6, 7, 8, 9, 10, 11, 12, 2};
		progMem[0] = encodeI(opLw, 0, 1, 16'd12);
		progMem[1] = encodeI(opAddi, 0, 2, 16'hfffb);
		progMem[2] = encodeI(opAddi, 0, 3, 16'd100);
		progMem[3] = encodeI(opLui, 0, 4, 16'h1234);
		// High bit set so zero extension shows
		progMem[4] = encodeI(opOri, 0, 5, 16'h8f0f);
		progMem[5] = encodeR(fnAdd, 1, 3, 6, 0);
		progMem[6] = encodeR(fnSub, 3, 2, 7, 0);
		progMem[7] = encodeR(fnAnd, 5, 2, 8, 0);
		progMem[8] = encodeR(fnOr, 4, 5, 9, 0);
		progMem[9] = encodeR(fnSlt, 2, 3, 10, 0);
		progMem[10] = encodeR(fnSll, 0, 5, 11, 4);
		progMem[11] = encodeR(fnSlt, 3, 2, 12, 0);
		// One result per word from resultBase
		for (int k = 0; k < 10; k++) begin
			progMem[12 + k] = encodeI(opSw, 0, storeRegs[k], 16'((resultBase + k) * 4));
		end
		progMem[22] = {opHalt, 26'd0};
	endtask

	////////////////////////////////////////////////////////////
	// Instruction level model of the program
	////////////////////////////////////////////////////////////
	task automatic runModel();
		logic [dataWidth-1:0] instr;
		logic [dataWidth-1:0] rsVal;
		logic [dataWidth-1:0] rtVal;
		logic [dataWidth-1:0] sext;
		logic [dataWidth-1:0] res;
		logic [4:0] dest;
		logic doWrite;
		int pcIdx;
		pcIdx = 0;
		for (int r = 0; r < 32; r++) begin
			modelRegs[r] = '0;
		end
		for (int i = 0; i < dataLen; i++) begin
			modelMem[i] = dataTable[i];
		end
		while (pcIdx < progLen && progMem[pcIdx][31:26] != opHalt) begin
			instr = progMem[pcIdx];
			rsVal = modelRegs[instr[25:21]];
			rtVal = modelRegs[instr[20:16]];
			sext = {{16{instr[15]}}, instr[15:0]};
			dest = instr[20:16];
			doWrite = 1'b1;
			res = '0;
			case (instr[31:26])
				opRtype: begin
					dest = instr[15:11];
					case (instr[5:0])
						fnAdd: res = rsVal + rtVal;
						fnSub: res = rsVal - rtVal;
						fnAnd: res = rsVal & rtVal;
						fnOr: res = rsVal | rtVal;
						fnSlt: res = ($signed(rsVal) < $signed(rtVal)) ? 32'd1 : 32'd0;
						fnSll: res = rtVal << instr[10:6];
						default: doWrite = 1'b0;
					endcase
				end
				opAddi: res = rsVal + sext;
				opOri: res = rsVal | {16'd0, instr[15:0]};
				opLui: res = {instr[15:0], 16'd0};
				opLw: res = modelMem[8'((rsVal + sext) >> 2)];
				opSw: begin
					modelMem[8'((rsVal + sext) >> 2)] = rtVal;
					doWrite = 1'b0;
				end
				default: doWrite = 1'b0;
			endcase
			if (doWrite && dest != 5'd0) begin
				modelRegs[dest] = res;
			end
			pcIdx++;
		end
	endtask

	task automatic addResultCheck(input int slot, input string name);
		chkName[slot] = name;
		chkAddr[slot] = wordAddr(resultBase + slot, 1'b0);
		chkData[slot] = modelMem[resultBase + slot];
		chkResp[slot] = respOkay;
	endtask

	task automatic buildChecks();
		addResultCheck(0, "lui");
		addResultCheck(1, "ori high bit");
		addResultCheck(2, "lw then add");
		addResultCheck(3, "sub");
		addResultCheck(4, "and");
		addResultCheck(5, "or");
		addResultCheck(6, "slt negative");
		addResultCheck(7, "sll");
		addResultCheck(8, "slt false");
		addResultCheck(9, "addi negative");
		// Program memory is write only
		chkName[10] = "program read";
		chkAddr[10] = wordAddr(3, 1'b1);
		chkData[10] = '0;
		chkResp[10] = respSlvErr;
	endtask

	////////////////////////////////////////////////////////////
	// Bus transactions
	////////////////////////////////////////////////////////////
	task automatic busWrite(input logic [busAddrWidth-1:0] addr,
			input logic [dataWidth-1:0] data, output logic [1:0] respOut);
		@(posedge clk);
		#driveDelay;
		awaddr = addr;
		wdata = data;
		awvalid = 1'b1;
		wvalid = 1'b1;
		bready = 1'b1;
		// Ready sampled mid cycle and taken on the next edge
		@(negedge clk);
		while (!awready) @(negedge clk);
		// Both channels are taken in the same cycle
		compareValue("wready", 32'(wready), 32'd1);
		@(posedge clk);
		#driveDelay;
		awvalid = 1'b0;
		wvalid = 1'b0;
		@(negedge clk);
		while (!bvalid) @(negedge clk);
		respOut = bresp;
		@(posedge clk);
		#driveDelay;
		bready = 1'b0;
	endtask

	task automatic busRead(input logic [busAddrWidth-1:0] addr,
			output logic [dataWidth-1:0] dataOut, output logic [1:0] respOut);
		@(posedge clk);
		#driveDelay;
		araddr = addr;
		arvalid = 1'b1;
		rready = 1'b1;
		@(negedge clk);
		while (!arready) @(negedge clk);
		@(posedge clk);
		#driveDelay;
		arvalid = 1'b0;
		@(negedge clk);
		while (!rvalid) @(negedge clk);
		dataOut = rdata;
		respOut = rresp;
		@(posedge clk);
		#driveDelay;
		rready = 1'b0;
	endtask

	task automatic compareValue(input string sigName, input logic [31:0] got,
			input logic [31:0] exp);
		if (got !== exp) begin
			$display("** Error: %s is 0x%08h, expected 0x%08h", sigName, got, exp);
			testErrors++;
		end
	endtask

	task automatic closeTest(input string name);
		if (testErrors == 0) begin
			passCount++;
			$display("Test ok: %s", name);
		end else begin
			failCount++;
			$display("Test failed: %s (%0d errors)", name, testErrors);
		end
		testErrors = 0;
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////
	initial begin
		reset = 1'b1;
		run = 1'b0;
		awvalid = 1'b0;
		awaddr = '0;
		wvalid = 1'b0;
		wdata = '0;
		bready = 1'b0;
		arvalid = 1'b0;
		araddr = '0;
		rready = 1'b0;
		passCount = 0;
		failCount = 0;
		testErrors = 0;
		seed = 2621;
		buildProgram();
		for (int i = 0; i < dataLen; i++) begin
			dataTable[i] = $random(seed);
		end
		runModel();
		buildChecks();
		repeat (10) @(posedge clk);
		#driveDelay;
		reset = 1'b0;

		for (int i = 0; i < progLen; i++) begin
			busWrite(wordAddr(i, 1'b1), progMem[i], resp);
			compareValue("bresp", 32'(resp), 32'(respOkay));
		end
		closeTest("program load");
		for (int i = 0; i < dataLen; i++) begin
			busWrite(wordAddr(i, 1'b0), dataTable[i], resp);
			compareValue("bresp", 32'(resp), 32'(respOkay));
		end
		closeTest("data preload");
		busRead(wordAddr(5, 1'b0), rdValue, resp);
		compareValue("rdata", rdValue, dataTable[5]);
		compareValue("rresp", 32'(resp), 32'(respOkay));
		closeTest("preload read-back");

		@(posedge clk);
		#driveDelay;
		run = 1'b1;
		// Would plant an early halt if the lock failed
		busWrite(wordAddr(14, 1'b1), {opHalt, 26'd0}, resp);
		compareValue("bresp", 32'(resp), 32'(respSlvErr));
		closeTest("locked program write");
		// Untouched words read while the program runs
		for (int i = 4; i < dataLen; i++) begin
			busRead(wordAddr(i, 1'b0), rdValue, resp);
			compareValue("rdata", rdValue, dataTable[i]);
			compareValue("rresp", 32'(resp), 32'(respOkay));
		end
		closeTest("reads under core traffic");

		while (!halted) @(negedge clk);
		closeTest("halt");
		for (int i = 0; i < checkLen; i++) begin
			busRead(chkAddr[i], rdValue, resp);
			compareValue("rdata", rdValue, chkData[i]);
			compareValue("rresp", 32'(resp), 32'(chkResp[i]));
			closeTest(chkName[i]);
		end
		if (halted !== 1'b1) begin
			$display("halted dropped after the program stopped");
			testErrors++;
		end
		closeTest("halted holds");

		$display("Tests passed: %0d, failed: %0d", passCount, failCount);
		if (failCount == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

	// Watchdog
	initial begin
		#(watchdogCycles * clkPeriod);
		$display("Watchdog expired before the tests finished");
		$display(">>> FAIL");
		$finish;
	end

endmodule

// File: src.f
rtl/cpuPkg.sv
rtl/instrDecoder.sv
rtl/regFile.sv
rtl/alu.sv
rtl/pipeline.sv
rtl/memArbiter.sv
rtl/debugPort.sv
rtl/cpuTop.sv
testbench/cpuTb.sv

// File: Makefile
TOP = cpuTb

.PHONY: sim clean

sim:
	verilator --binary --timing -f src.f --top-module $(TOP) -Mdir obj_dir -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; echo "$$out" | grep -qxF '>>> PASS'

clean:
	rm -rf obj_dir
